// File: src/glue_pkg.sv
package glue_pkg;

	// ------------------------------------------------------------
	// cpu side buses
	// ------------------------------------------------------------

	typedef logic [15:0] data_word_t;	// cpu and chip data word
	typedef logic [23:1] cpu_addr_t;	// word address, a0 is implied by the strobes

	// ------------------------------------------------------------
	// battery clock
	// ------------------------------------------------------------

	// one bcd digit or raw clock nibble
	typedef logic [3:0] bcd_digit_t;

	// 16 nibbles of time
	// nibble 0 holds seconds units and nibble 1 holds seconds tens
	typedef logic [63:0] rtc_time_t;

	// host word with the load flag in the top bit
	typedef logic [64:0] rtc_load_t;

	// ------------------------------------------------------------
	// reset sequencer
	// ------------------------------------------------------------

	typedef enum logic [1:0] {
		st_hold,	// reset forced by rst_n or rst_ext
		st_count,	// counting start-of-frame strobes
		st_run		// system released
	} reset_state_t;

endpackage

// File: src/sys_reset_ctrl.sv
module sys_reset_ctrl
	import glue_pkg::*;
#(
	parameter int unsigned RESET_FRAMES = 8,	// frames of reset after rst_ext drops
	parameter bit          NTSC         = 1'b0	// video mode out of power-up
) (
	input  logic clk,
	input  logic rst_n,
	input  logic rst_ext,	// reset request from the host side
	input  logic sof,		// one-cycle start of frame strobe
	input  logic cpu_reset_in_n,	// cpu executing its own reset
	input  logic ntsc_cfg,
	output logic sys_reset,
	output logic rst_out,
	output logic cpu_reset_n,
	output logic ntsc
);

	localparam int unsigned cnt_w = (RESET_FRAMES > 1) ? $clog2(RESET_FRAMES) : 1;
	localparam logic [cnt_w-1:0] last_frame = cnt_w'(RESET_FRAMES - 1);

	reset_state_t     state;
	logic [cnt_w-1:0] frame_cnt;	// strobes seen in st_count
	logic             rst_sync;	// first stage of the cpu reset chain

	// ------------------------------------------------------------
	// frame counting fsm
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n || rst_ext) begin
			state     <= st_hold;
			frame_cnt <= '0;
		end else begin
			case (state)
				st_hold: begin
					state     <= st_count;	// rst_ext released
					frame_cnt <= '0;
				end
				st_count: begin
					if (sof) begin
						if (frame_cnt == last_frame)
							state <= st_run;	// last frame seen, let go
						else
							frame_cnt <= frame_cnt + 1'b1;
					end
				end
				st_run:  state <= st_run;	// stays until rst_ext
				default: state <= st_hold;
			endcase
		end
	end

	assign sys_reset = (state != st_run);
	assign rst_out   = sys_reset | ~cpu_reset_in_n;	// either side holds the chipset

	// two flops to the cpu reset pin
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rst_sync    <= 1'b0;
			cpu_reset_n <= 1'b0;
		end else begin
			rst_sync    <= ~sys_reset;
			cpu_reset_n <= rst_sync;
		end
	end

	// pal/ntsc only follows the config during reset
	always_ff @(posedge clk) begin
		if (!rst_n)
			ntsc <= NTSC;
		else if (rst_out)
			ntsc <= ntsc_cfg;
	end

endmodule

// File: src/rtc_clock.sv
module rtc_clock
	import glue_pkg::*;
#(
	parameter int unsigned TICKS_PER_SEC = 28375160	// clk cycles in one second
) (
	input  logic       clk,
	input  logic       rst_n,
	input  rtc_load_t  rtc_load,	// host time, flag on top
	input  cpu_addr_t  cpu_addr,
	input  logic       sel_rtc,
	input  logic       rd,
	output data_word_t rtc_data
);

	localparam int unsigned tick_w = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
	localparam logic [tick_w-1:0] last_tick = tick_w'(TICKS_PER_SEC - 1);

	rtc_time_t         time_q;	// running clock register
	logic [tick_w-1:0] tick_cnt;	// one second divider
	logic              flag_q;	// last seen host flag
	logic              load;
	logic              sec_wrap;
	bcd_digit_t        sec_ones;
	bcd_digit_t        sec_tens;
	logic [3:0]        nib_sel;
	bcd_digit_t        rd_nibble;

	assign load     = flag_q ^ rtc_load[64];	// host toggled the flag
	assign sec_wrap = (tick_cnt == last_tick);
	assign sec_ones = time_q[3:0];
	assign sec_tens = time_q[7:4];

	always_ff @(posedge clk) begin
		if (!rst_n)
			flag_q <= 1'b0;
		else
			flag_q <= rtc_load[64];
	end

	// ------------------------------------------------------------
	// second divider
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n)
			tick_cnt <= '0;
		else if (load || sec_wrap)
			tick_cnt <= '0;	// a load restarts the second
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// host load and bcd seconds
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			time_q <= '0;
		end else if (load) begin
			time_q <= {rtc_load[63:8], 8'h00};	// seconds start from 00
		end else if (sec_wrap) begin
			if (sec_ones < 4'd9)
				time_q[3:0] <= sec_ones + 4'd1;
			else if (sec_tens < 4'd5)
				time_q[7:0] <= {sec_tens + 4'd1, 4'd0};	// carry into tens
			// 59 sticks until the host loads again
		end
	end

	// ------------------------------------------------------------
	// cpu read port
	// ------------------------------------------------------------

	assign nib_sel   = cpu_addr[5:2];
	assign rd_nibble = time_q[{nib_sel, 2'b00} +: 4];
	assign rtc_data  = (sel_rtc && rd) ? {12'h000, rd_nibble} : '0;	// quiet unless read

endmodule

// File: src/cpu_bus_glue.sv
module cpu_bus_glue
	import glue_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       cpu_reset_n,	// reset driven to the cpu
	input  logic       cpu_reset_in_n,	// reset instruction from the cpu
	input  logic       sel_cia_a,
	input  logic       hwr,
	input  logic       lwr,
	input  data_word_t gary_data,
	input  data_word_t cia_data,
	input  data_word_t rtc_data,
	output logic       ovl,	// kickstart overlay at address zero
	output data_word_t cpu_data
);

	logic cpu_in_reset;
	logic cia_a_write;

	assign cpu_in_reset = ~cpu_reset_n | ~cpu_reset_in_n;
	assign cia_a_write  = sel_cia_a & (hwr | lwr);	// either byte lane

	// ------------------------------------------------------------
	// overlay flag
	// ------------------------------------------------------------

	// rom mapped low on every reset
	// first cia-a access by kickstart maps chip ram back in
	always_ff @(posedge clk) begin
		if (!rst_n)
			ovl <= 1'b1;
		else if (cpu_in_reset)
			ovl <= 1'b1;	// set beats clear
		else if (cia_a_write)
			ovl <= 1'b0;
	end

	// ------------------------------------------------------------
	// read data merge
	// ------------------------------------------------------------

	// sources drive zero when not selected
	assign cpu_data = gary_data | cia_data | rtc_data;

endmodule

// File: src/minimig_glue.sv
module minimig_glue
	import glue_pkg::*;
#(
	parameter int unsigned RESET_FRAMES  = 8,
	parameter int unsigned TICKS_PER_SEC = 28375160,
	parameter bit          NTSC          = 1'b0
) (
	input  logic       clk,
	input  logic       rst_n,
	// reset and video
	input  logic       rst_ext,
	input  logic       sof,
	input  logic       cpu_reset_in_n,
	input  logic       ntsc_cfg,
	// battery clock host word
	input  rtc_load_t  rtc_load,
	// cpu bus
	input  cpu_addr_t  cpu_addr,
	input  logic       sel_rtc,
	input  logic       sel_cia_a,
	input  logic       rd,
	input  logic       hwr,
	input  logic       lwr,
	input  data_word_t gary_data,	// memory side read data
	input  data_word_t cia_data,	// both cias, one per byte lane
	output logic       rst_out,
	output logic       cpu_reset_n,
	output logic       ntsc,
	output logic       ovl,
	output data_word_t cpu_data
);

	data_word_t rtc_data;	// clock nibble into the read merge

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------

	sys_reset_ctrl #(
		.RESET_FRAMES (RESET_FRAMES),
		.NTSC         (NTSC)
	) u_reset (
		.clk            (clk),
		.rst_n          (rst_n),
		.rst_ext        (rst_ext),
		.sof            (sof),
		.cpu_reset_in_n (cpu_reset_in_n),
		.ntsc_cfg       (ntsc_cfg),
		.sys_reset      (),	// reaches the pins through rst_out
		.rst_out        (rst_out),
		.cpu_reset_n    (cpu_reset_n),
		.ntsc           (ntsc)
	);

	// ------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------

	rtc_clock #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) u_rtc (
		.clk      (clk),
		.rst_n    (rst_n),
		.rtc_load (rtc_load),
		.cpu_addr (cpu_addr),
		.sel_rtc  (sel_rtc),
		.rd       (rd),
		.rtc_data (rtc_data)
	);

	cpu_bus_glue u_bus (
		.clk            (clk),
		.rst_n          (rst_n),
		.cpu_reset_n    (cpu_reset_n),
		.cpu_reset_in_n (cpu_reset_in_n),
		.sel_cia_a      (sel_cia_a),
		.hwr            (hwr),
		.lwr            (lwr),
		.gary_data      (gary_data),
		.cia_data       (cia_data),
		.rtc_data       (rtc_data),
		.ovl            (ovl),
		.cpu_data       (cpu_data)
	);

endmodule

// File: sim/minimig_glue_properties.sv
module minimig_glue_properties
	import glue_pkg::*;
#(
	parameter bit RESET_SIDE = 1'b1	// 1 inside sys_reset_ctrl, 0 inside cpu_bus_glue
) (
	input logic         clk,
	input logic         rst_n,
	input logic         cpu_reset_n,
	input logic         sys_reset,
	input reset_state_t state,
	input logic         ovl
);

	if (RESET_SIDE) begin : g_reset
		// two flop chain from the sequencer to the cpu pin
		a_cpu_reset_delay: assert property (@(posedge clk) disable iff (!rst_n)
			cpu_reset_n == !$past(sys_reset, 2))
			else $error("cpu_reset_n is not sys_reset inverted two cycles back");
		// hold never releases straight away, count comes first
		a_hold_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
			(state == st_hold) |-> sys_reset ##1 sys_reset)
			else $error("sys_reset low in or right after st_hold");
	end else begin : g_overlay
		a_ovl_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
			!cpu_reset_n |=> ovl)
			else $error("ovl not set one cycle after cpu reset");
	end

endmodule

bind sys_reset_ctrl minimig_glue_properties #(.RESET_SIDE(1'b1)) u_reset_props (
	.clk(clk), .rst_n(rst_n), .cpu_reset_n(cpu_reset_n), .sys_reset(sys_reset),
	.state(state), .ovl(1'b1));

bind cpu_bus_glue minimig_glue_properties #(.RESET_SIDE(1'b0)) u_bus_props (
	.clk(clk), .rst_n(rst_n), .cpu_reset_n(cpu_reset_n), .sys_reset(1'b0),
	.state(st_run), .ovl(ovl));

// File: sim/tb_minimig_glue.sv
module tb_minimig_glue
	import glue_pkg::*;
();

	localparam int period = 20;
	localparam int frames = 4;
	localparam int ticks  = 20;
	// reset runs, overlay and ntsc steps, nibble reads, seconds sweep, random merge
	localparam int test_cycles = 8 + 2 * (frames * 9 + 2) + 80 + 64 * ticks + 240;
	localparam int timeout_cycles = test_cycles + 500;

	logic       clk;
	logic       rst_n;
	logic       rst_ext;
	logic       sof;
	logic       cpu_reset_in_n;
	logic       ntsc_cfg;
	rtc_load_t  rtc_load;
	cpu_addr_t  cpu_addr;
	logic       sel_rtc;
	logic       sel_cia_a;
	logic       rd;
	logic       hwr;
	logic       lwr;
	data_word_t gary_data;
	data_word_t cia_data;
	logic       rst_out;
	logic       cpu_reset_n;
	logic       ntsc;
	logic       ovl;
	data_word_t cpu_data;

	logic [31:0] lfsr;
	int unsigned errors;
	rtc_time_t   ref_time;	// time as last loaded
	int unsigned ref_cycles;	// cycles since that load
	logic        ref_flag;	// host flag as the clock last saw it
	rtc_time_t   host_time;

	minimig_glue #(
		.RESET_FRAMES  (frames),
		.TICKS_PER_SEC (ticks),
		.NTSC          (1'b0)
	) uut (.*);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// ------------------------------------------------------------
	// random bits, reference and compare
	// ------------------------------------------------------------

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);	// galois step
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	// seconds from elapsed ticks, saturating at 59, then nibble pick and or
	function automatic data_word_t expected_data(input rtc_time_t loaded,
			input int unsigned cycles, input cpu_addr_t addr, input logic sel,
			input logic rd_en, input data_word_t gary, input data_word_t cia);
		rtc_time_t   t;
		int unsigned secs;
		bcd_digit_t  nib;
		secs = cycles / ticks;
		if (secs > 59)
			secs = 59;
		t = loaded;
		t[3:0] = bcd_digit_t'(secs % 10);
		t[7:4] = bcd_digit_t'(secs / 10);
		nib = t[int'(addr[5:2]) * 4 +: 4];
		return gary | cia | ((sel && rd_en) ? {12'h000, nib} : 16'h0000);
	endfunction

	task automatic compare_values(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	always @(posedge clk) begin
		if (rst_n)
			compare_values("cpu_data", 64'(cpu_data), 64'(expected_data(ref_time,
				ref_cycles, cpu_addr, sel_rtc, rd, gary_data, cia_data)));
		if (!rst_n) begin
			ref_time   = '0;
			ref_cycles = 0;
			ref_flag   = 1'b0;
		end else if (rtc_load[64] != ref_flag) begin
			ref_time   = {rtc_load[63:8], 8'h00};	// flag toggled, seconds from 00
			ref_cycles = 0;
			ref_flag   = rtc_load[64];
		end else begin
			ref_cycles++;
		end
	end

	initial begin
		#(timeout_cycles * period);
		$display("Timeout: tests did not finish within %0d cycles", timeout_cycles);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	// ------------------------------------------------------------
	// stimulus tasks
	// ------------------------------------------------------------

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// frame strobes at random spacing, then the cpu reset two cycles behind
	task automatic run_frames();
		int gap;
		for (int f = 0; f < frames; f++) begin
			gap = 1 + int'(rand_bits(3));
			repeat (gap) begin
				@(negedge clk);
				compare_values("rst_out", 64'(rst_out), 64'(1));
			end
			sof = 1'b1;
			@(negedge clk);
			sof = 1'b0;
		end
		compare_values("rst_out", 64'(rst_out), 64'(0));
		compare_values("cpu_reset_n", 64'(cpu_reset_n), 64'(0));
		@(negedge clk);
		compare_values("cpu_reset_n", 64'(cpu_reset_n), 64'(0));
		@(negedge clk);
		compare_values("cpu_reset_n", 64'(cpu_reset_n), 64'(1));
	endtask

	task automatic read_nibble(input int idx, input bcd_digit_t exp);
		cpu_addr      = cpu_addr_t'(rand_bits(23));	// junk outside the nibble index
		cpu_addr[5:2] = idx[3:0];
		sel_rtc       = 1'b1;
		rd            = 1'b1;
		@(negedge clk);
		compare_values("cpu_data", 64'(cpu_data), 64'(exp));
	endtask

	task automatic load_clock(input rtc_time_t t);
		rtc_load = {~rtc_load[64], t};
		@(negedge clk);
	endtask

	initial begin
		int sec;
		lfsr           = 32'hdca5b213;
		errors         = 0;
		rst_n          = 1'b0;
		rst_ext        = 1'b0;
		sof            = 1'b0;
		cpu_reset_in_n = 1'b1;
		ntsc_cfg       = 1'b0;
		rtc_load       = '0;
		cpu_addr       = '0;
		sel_rtc        = 1'b0;
		sel_cia_a      = 1'b0;
		rd             = 1'b0;
		hwr            = 1'b0;
		lwr            = 1'b0;
		gary_data      = '0;
		cia_data       = '0;
		wait_cycles(8);
		rst_n = 1'b1;
		run_frames();
		compare_values("ntsc", 64'(ntsc), 64'(0));

		// overlay flag
		compare_values("ovl", 64'(ovl), 64'(1));
		hwr = 1'b1;	// write to something other than cia-a
		@(negedge clk);
		hwr = 1'b0;
		compare_values("ovl", 64'(ovl), 64'(1));
		sel_cia_a = 1'b1;
		lwr       = 1'b1;
		@(negedge clk);
		sel_cia_a = 1'b0;
		lwr       = 1'b0;
		compare_values("ovl", 64'(ovl), 64'(0));
		cpu_reset_in_n = 1'b0;	// reset instruction
		@(negedge clk);
		compare_values("rst_out", 64'(rst_out), 64'(1));
		compare_values("ovl", 64'(ovl), 64'(1));
		cpu_reset_in_n = 1'b1;
		@(negedge clk);
		compare_values("rst_out", 64'(rst_out), 64'(0));

		// external reset rerun, video mode only latched inside it
		ntsc_cfg = 1'b1;
		wait_cycles(3);
		compare_values("ntsc", 64'(ntsc), 64'(0));
		rst_ext = 1'b1;
		@(negedge clk);
		compare_values("rst_out", 64'(rst_out), 64'(1));
		wait_cycles(2);
		compare_values("cpu_reset_n", 64'(cpu_reset_n), 64'(0));
		rst_ext = 1'b0;
		run_frames();
		compare_values("ntsc", 64'(ntsc), 64'(1));
		ntsc_cfg = 1'b0;
		wait_cycles(3);
		compare_values("ntsc", 64'(ntsc), 64'(1));

		// clock load and all nibbles, seconds still 00
		host_time = rand_bits(64);
		load_clock(host_time);
		for (int n = 0; n < 16; n++)
			read_nibble(n, (n < 2) ? 4'h0 : host_time[n * 4 +: 4]);
		rd = 1'b0;
		@(negedge clk);
		compare_values("cpu_data", 64'(cpu_data), 64'(0));

		// seconds sweep, reads in the middle of each second
		host_time = rand_bits(64);
		load_clock(host_time);
		wait_cycles(ticks / 2);
		for (int s = 0; s < 64; s++) begin
			sec = (s > 59) ? 59 : s;
			read_nibble(0, bcd_digit_t'(sec % 10));
			read_nibble(1, bcd_digit_t'(sec / 10));
			wait_cycles(ticks - 2);
		end
		for (int n = 2; n < 16; n++)
			read_nibble(n, host_time[n * 4 +: 4]);

		// random merge, checked by the compare process
		repeat (200) begin
			gary_data = data_word_t'(rand_bits(16));
			cia_data  = data_word_t'(rand_bits(16));
			cpu_addr  = cpu_addr_t'(rand_bits(23));
			sel_rtc   = rand_bits(1) != 0;
			rd        = rand_bits(1) != 0;
			@(negedge clk);
		end
		wait_cycles(2);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: src.f
src/glue_pkg.sv
src/sys_reset_ctrl.sv
src/rtc_clock.sv
src/cpu_bus_glue.sv
src/minimig_glue.sv
sim/minimig_glue_properties.sv
sim/tb_minimig_glue.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_minimig_glue
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "test passed"; \
	else echo "test failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
